/* sim.f */
+incdir+rtl
+incdir+verification
rtl/pre_track_pkg.sv
rtl/pre_track_cfg_regs.sv
rtl/pingpong_wr_steer.sv
rtl/readback_hit_detect.sv
rtl/hit_history_ram.sv
rtl/window_presence.sv
rtl/pre_track_top.sv
verification/tb_pre_track.sv

/* verification/tb_pre_track_model.svh */
`ifndef TB_PRE_TRACK_MODEL_SVH
`define TB_PRE_TRACK_MODEL_SVH

// write side state, as seen during the current cycle
logic    m_bank_b = 1'b0;
logic    m_second = 1'b0;
logic    m_vld_a  = 1'b0;
logic    m_vld_b  = 1'b0;
pair_t   m_pair   = '0;

// readback pipeline, capture stage then compare stage
logic    m_p1_vld   = 1'b0;
sample_t m_p1_laser = '0;
sample_t m_p1_haze  = '0;
logic    m_p2_vld   = 1'b0;
logic    m_p2_hit   = 1'b0;

// settings and the last W hits of the scan
sample_t m_thresh = '0;
int      m_win    = 1;
int      m_hits[$];
int      m_sum    = 0;
logic    m_result = 1'b0;

// laser minus haze, clamped at zero, strictly above the threshold
function automatic logic hit_rule(input sample_t laser, input sample_t haze, input sample_t th);
    int diff;
    diff = int'(laser) - int'(haze);
    if (diff < 0) begin
        diff = 0;
    end
    return diff > int'(th);
endfunction

// advance the model by one clock edge using the inputs of this cycle
task automatic model_step();
    logic     sel_vld;
    rd_word_t sel_word;
    logic     nx_hit;
    logic     nx_result;
    m_vld_a  = laser_start_i & laser_pre_vld_i & ~m_bank_b;
    m_vld_b  = laser_start_i & laser_pre_vld_i & m_bank_b;
    m_pair   = {haze_data_i, laser_data_i};
    m_second = laser_start_i & (m_second | encode_zero_i);
    // readback comes from the bank that is not being written
    sel_vld  = m_bank_b ? mema_rd_vld_i : memb_rd_vld_i;
    sel_word = m_bank_b ? mema_rd_data_i : memb_rd_data_i;
    m_bank_b = laser_start_i & (m_bank_b ^ encode_zero_i);
    nx_hit    = m_p1_vld && hit_rule(m_p1_laser, m_p1_haze, m_thresh);
    nx_result = (m_sum != 0);
    if (!laser_start_i) begin
        m_hits.delete();
        m_sum = 0;
    end else if (m_p2_vld) begin
        m_hits.push_back(int'(m_p2_hit));
        m_sum += int'(m_p2_hit);
        if (m_hits.size() > m_win) begin
            m_sum -= m_hits.pop_front();
        end
    end
    m_result = nx_result;
    m_p2_vld = m_p1_vld;
    m_p2_hit = nx_hit;
    m_p1_vld = sel_vld;
    if (sel_vld) begin
        m_p1_laser = sel_word[15:0];
        m_p1_haze  = sel_word[31:16];
    end
    // new settings apply from the next cycle on
    if (cfg_wr_i) begin
        m_thresh = cfg_thresh_i;
        m_win    = (cfg_win_i == '0) ? 1 : int'(cfg_win_i);
    end
endtask

`endif

/* verification/tb_pre_track.sv */
`timescale 1ns/1ps

module tb_pre_track;
    import pre_track_pkg::*;

    localparam int IDLE_CYC   = 8;
    localparam int STEER_CYC  = 200;
    localparam int SCANS      = 4;
    localparam int SCAN_CYC   = 40;
    localparam int GAP_CYC    = 4;
    localparam int HIT_CYC    = 300;
    localparam int WIN_ROUNDS = 6;
    localparam int WIN_CYC    = 160;
    // every stimulus cycle, reset and config writes included
    localparam int TOTAL_CYC  = 2 + IDLE_CYC + STEER_CYC + GAP_CYC
                              + SCANS * (SCAN_CYC + GAP_CYC) + 2 + HIT_CYC + GAP_CYC
                              + WIN_ROUNDS * (GAP_CYC + 2 + WIN_CYC) + GAP_CYC;
    localparam int CYCLE_LIMIT = 2 * TOTAL_CYC;

    logic clk_i, rst_n_i, cfg_wr_i;
    sample_t cfg_thresh_i, laser_data_i, haze_data_i;
    win_len_t cfg_win_i;
    logic laser_start_i, encode_zero_i, laser_pre_vld_i, mema_rd_vld_i, memb_rd_vld_i;
    rd_word_t mema_rd_data_i, memb_rd_data_i;
    logic mema_start_o, memb_start_o, mema_vld_o, memb_vld_o;
    pair_t mema_data_o, memb_data_o;
    logic second_track_en_o, pre_track_result_o;

    logic [31:0] lfsr_state = 32'hef5e_c10d;
    string cur_test;
    int test_chk, test_err, total_chk, total_err, tests_passed, tests_failed;
    int cycle_cnt = 0;
    logic chk_idle = 1'b0;
    logic chk_write = 1'b0;
    logic chk_second = 1'b0;
    logic chk_result = 1'b0;

    `include "tb_pre_track_model.svh"

    pre_track_top u_dut (.*);

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // random source, x^32 + x^22 + x^2 + x + 1

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        test_chk++;
        total_chk++;
        assert (act === exp) else begin
            $display("FAILED %s %s expected %0h actual %0h", cur_test, what, exp, act);
            test_err++;
            total_err++;
        end
    endtask

    task automatic run_checks();
        if (chk_idle) begin
            check_val("mema_start_o", 0, mema_start_o);
            check_val("memb_start_o", 0, memb_start_o);
            check_val("mema_vld_o", 0, mema_vld_o);
            check_val("memb_vld_o", 0, memb_vld_o);
            check_val("second_track_en_o", 0, second_track_en_o);
            check_val("pre_track_result_o", 0, pre_track_result_o);
        end
        if (chk_write) begin
            check_val("mema_start_o", laser_start_i & ~m_bank_b, mema_start_o);
            check_val("memb_start_o", laser_start_i & m_bank_b, memb_start_o);
            check_val("mema_vld_o", m_vld_a, mema_vld_o);
            check_val("memb_vld_o", m_vld_b, memb_vld_o);
            if (m_vld_a) begin
                check_val("mema_data_o", m_pair, mema_data_o);
            end
            if (m_vld_b) begin
                check_val("memb_data_o", m_pair, memb_data_o);
            end
        end
        if (chk_second) begin
            check_val("second_track_en_o", m_second, second_track_en_o);
        end
        if (chk_result) begin
            check_val("pre_track_result_o", m_result, pre_track_result_o);
        end
    endtask

    // check mid-cycle, step the model, then wait for the next drive point
    task automatic tick();
        @(negedge clk_i);
        run_checks();
        model_step();
        @(posedge clk_i);
        #1;
    endtask

    task automatic clear_stim();
        cfg_wr_i        = 1'b0;
        cfg_thresh_i    = '0;
        cfg_win_i       = '0;
        laser_start_i   = 1'b0;
        encode_zero_i   = 1'b0;
        laser_pre_vld_i = 1'b0;
        laser_data_i    = '0;
        haze_data_i     = '0;
        mema_rd_vld_i   = 1'b0;
        mema_rd_data_i  = '0;
        memb_rd_vld_i   = 1'b0;
        memb_rd_data_i  = '0;
    endtask

    task automatic write_cfg(input sample_t th, input win_len_t w);
        cfg_wr_i     = 1'b1;
        cfg_thresh_i = th;
        cfg_win_i    = w;
        tick();
        cfg_wr_i = 1'b0;
        tick();
    endtask

    task automatic drive_readback();
        mema_rd_vld_i  = (rand_bits(1) != 0);
        mema_rd_data_i = rand_bits(64);
        memb_rd_vld_i  = (rand_bits(1) != 0);
        memb_rd_data_i = rand_bits(64);
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_chk = 0;
        test_err = 0;
    endtask

    task automatic end_test();
        if (test_err == 0) begin
            $display("%-16s passed, %0d checks", cur_test, test_chk);
            tests_passed++;
        end else begin
            $display("%-16s failed, %0d of %0d checks wrong", cur_test, test_err, test_chk);
            tests_failed++;
        end
    endtask

    //////////////////////////////////////////////////
    // test sequence

    initial begin
        clk_i   = 1'b0;
        rst_n_i = 1'b0;
        clear_stim();
        repeat (2) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        begin_test("reset_idle");
        chk_idle = 1'b1;
        repeat (IDLE_CYC) tick();
        chk_idle = 1'b0;
        end_test();

        begin_test("bank_steer");
        chk_write = 1'b1;
        for (int i = 0; i < STEER_CYC; i++) begin
            laser_start_i   = 1'b1;
            encode_zero_i   = (rand_bits(3) == 0);
            laser_pre_vld_i = (rand_bits(1) != 0);
            laser_data_i    = sample_t'(rand_bits(16));
            haze_data_i     = sample_t'(rand_bits(16));
            tick();
        end
        clear_stim();
        repeat (GAP_CYC) tick();
        chk_write = 1'b0;
        end_test();

        begin_test("second_track");
        chk_second = 1'b1;
        repeat (SCANS) begin
            for (int i = 0; i < SCAN_CYC; i++) begin
                laser_start_i = 1'b1;
                encode_zero_i = (rand_bits(3) == 0);
                tick();
            end
            clear_stim();
            repeat (GAP_CYC) tick();
        end
        chk_second = 1'b0;
        end_test();

        // single-entry window, so presence is the latest hit bit
        begin_test("hit_threshold");
        chk_result = 1'b1;
        write_cfg(sample_t'(rand_bits(12)), win_len_t'(1));
        for (int i = 0; i < HIT_CYC; i++) begin
            laser_start_i = 1'b1;
            encode_zero_i = (rand_bits(3) == 0);
            drive_readback();
            tick();
        end
        clear_stim();
        repeat (GAP_CYC) tick();
        end_test();

        // high threshold keeps hits sparse, short drop of the scan mid-round
        begin_test("window_presence");
        repeat (WIN_ROUNDS) begin
            clear_stim();
            repeat (GAP_CYC) tick();
            write_cfg(16'ha000, win_len_t'(2 + rand_bits(6) % 39));
            for (int i = 0; i < WIN_CYC; i++) begin
                laser_start_i = !(i >= 90 && i < 93);
                encode_zero_i = (rand_bits(3) == 0);
                drive_readback();
                tick();
            end
        end
        clear_stim();
        repeat (GAP_CYC) tick();
        chk_result = 1'b0;
        end_test();

        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, total_chk, total_err);
        if (total_err == 0 && tests_failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* rtl/pre_track_top.sv */
`timescale 1ns/1ps

module pre_track_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    cfg_wr_i,
    input  pre_track_pkg::sample_t  cfg_thresh_i,
    input  pre_track_pkg::win_len_t cfg_win_i,
    input  logic                    laser_start_i,
    input  logic                    encode_zero_i,
    input  logic                    laser_pre_vld_i,
    input  pre_track_pkg::sample_t  laser_data_i,
    input  pre_track_pkg::sample_t  haze_data_i,
    output logic                    mema_start_o,
    output logic                    memb_start_o,
    output logic                    mema_vld_o,
    output logic                    memb_vld_o,
    output pre_track_pkg::pair_t    mema_data_o,
    output pre_track_pkg::pair_t    memb_data_o,
    output logic                    second_track_en_o,
    input  logic                    mema_rd_vld_i,
    input  pre_track_pkg::rd_word_t mema_rd_data_i,
    input  logic                    memb_rd_vld_i,
    input  pre_track_pkg::rd_word_t memb_rd_data_i,
    output logic                    pre_track_result_o
);
    import pre_track_pkg::*;

    sample_t  thresh;
    win_len_t win_len;
    logic     wr_bank_b;
    logic     hit_vld;
    logic     hit;

    //////////////////////////////////////////////////
    // configuration

    pre_track_cfg_regs u_cfg_regs (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .cfg_wr_i     (cfg_wr_i),
        .cfg_thresh_i (cfg_thresh_i),
        .cfg_win_i    (cfg_win_i),
        .thresh_o     (thresh),
        .win_len_o    (win_len)
    );

    //////////////////////////////////////////////////
    // ping-pong write side

    pingpong_wr_steer u_wr_steer (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .laser_start_i     (laser_start_i),
        .encode_zero_i     (encode_zero_i),
        .laser_pre_vld_i   (laser_pre_vld_i),
        .laser_data_i      (laser_data_i),
        .haze_data_i       (haze_data_i),
        .wr_bank_b_o       (wr_bank_b),
        .mema_start_o      (mema_start_o),
        .memb_start_o      (memb_start_o),
        .mema_vld_o        (mema_vld_o),
        .memb_vld_o        (memb_vld_o),
        .mema_data_o       (mema_data_o),
        .memb_data_o       (memb_data_o),
        .second_track_en_o (second_track_en_o)
    );

    //////////////////////////////////////////////////
    // readback and presence

    // readback follows the bank opposite to the write side
    readback_hit_detect u_hit_detect (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .wr_bank_b_i    (wr_bank_b),
        .thresh_i       (thresh),
        .mema_rd_vld_i  (mema_rd_vld_i),
        .mema_rd_data_i (mema_rd_data_i),
        .memb_rd_vld_i  (memb_rd_vld_i),
        .memb_rd_data_i (memb_rd_data_i),
        .hit_vld_o      (hit_vld),
        .hit_o          (hit)
    );

    window_presence u_window (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .laser_start_i      (laser_start_i),
        .win_len_i          (win_len),
        .hit_vld_i          (hit_vld),
        .hit_i              (hit),
        .pre_track_result_o (pre_track_result_o)
    );

endmodule

/* rtl/window_presence.sv */
`timescale 1ns/1ps

module window_presence (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    laser_start_i,
    input  pre_track_pkg::win_len_t win_len_i,
    input  logic                    hit_vld_i,
    input  logic                    hit_i,
    output logic                    pre_track_result_o
);
    import pre_track_pkg::*;

    hist_addr_t hist_waddr;
    hist_addr_t hist_raddr;
    logic       hist_we;
    logic       hist_wbit;
    logic       hist_rbit;
    win_len_t   fill_cnt;
    logic       window_full;
    hit_sum_t   hit_sum;
    hit_sum_t   sum_add;
    hit_sum_t   sum_drop;
    logic       result;

    //////////////////////////////////////////////////
    // history memory

    assign hist_we   = hit_vld_i & laser_start_i;
    assign hist_wbit = hit_i;

    // entry written W hits ago
    assign hist_raddr = hist_waddr - win_len_i;

    hit_history_ram u_hist_ram (
        .clk_i   (clk_i),
        .we_i    (hist_we),
        .waddr_i (hist_waddr),
        .wbit_i  (hist_wbit),
        .raddr_i (hist_raddr),
        .rbit_o  (hist_rbit)
    );

    //////////////////////////////////////////////////
    // fill counter and running sum

    assign window_full = (fill_cnt >= win_len_i);
    assign sum_add     = hit_sum_t'(hit_i);
    assign sum_drop    = window_full ? hit_sum_t'(hist_rbit) : '0;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hist_waddr <= '0;
            fill_cnt   <= '0;
            hit_sum    <= '0;
        end else if (!laser_start_i) begin
            hist_waddr <= '0;
            fill_cnt   <= '0;
            hit_sum    <= '0;
        end else if (hit_vld_i) begin
            hist_waddr <= hist_waddr + 1'b1;
            if (!window_full) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
            hit_sum <= hit_sum + sum_add - sum_drop;
        end
    end

    // presence means any hit left inside the window
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            result <= 1'b0;
        end else begin
            result <= |hit_sum;
        end
    end

    assign pre_track_result_o = result;

endmodule

/* rtl/hit_history_ram.sv */
`timescale 1ns/1ps
`include "pre_track_consts.svh"

module hit_history_ram (
    input  logic                      clk_i,
    input  logic                      we_i,
    input  pre_track_pkg::hist_addr_t waddr_i,
    input  logic                      wbit_i,
    input  pre_track_pkg::hist_addr_t raddr_i,
    output logic                      rbit_o
);

    // one hit bit per entry, written in arrival order
    logic mem [`PT_HIST_DEPTH];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[waddr_i] <= wbit_i;
        end
    end

    // asynchronous read so the oldest bit is ready with the new hit
    assign rbit_o = mem[raddr_i];

endmodule

/* rtl/readback_hit_detect.sv */
`timescale 1ns/1ps
`include "pre_track_consts.svh"

module readback_hit_detect (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    wr_bank_b_i,
    input  pre_track_pkg::sample_t  thresh_i,
    input  logic                    mema_rd_vld_i,
    input  pre_track_pkg::rd_word_t mema_rd_data_i,
    input  logic                    memb_rd_vld_i,
    input  pre_track_pkg::rd_word_t memb_rd_data_i,
    output logic                    hit_vld_o,
    output logic                    hit_o
);
    import pre_track_pkg::*;

    logic                  sel_vld;
    rd_word_t              sel_data;
    logic                  rd_vld;
    sample_t               rd_laser;
    sample_t               rd_haze;
    logic [`PT_SAMPLE_W:0] diff;
    sample_t               diff_clamped;
    logic                  hit_vld;
    logic                  hit;

    // read from the bank that is not being written
    assign sel_vld  = wr_bank_b_i ? mema_rd_vld_i : memb_rd_vld_i;
    assign sel_data = wr_bank_b_i ? mema_rd_data_i : memb_rd_data_i;

    //////////////////////////////////////////////////
    // stage 1, readback capture

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_vld <= 1'b0;
        end else begin
            rd_vld <= sel_vld;
        end
    end

    always_ff @(posedge clk_i) begin
        if (sel_vld) begin
            rd_laser <= sel_data[`PT_SAMPLE_W-1:0];
            rd_haze  <= sel_data[2*`PT_SAMPLE_W-1:`PT_SAMPLE_W];
        end
    end

    //////////////////////////////////////////////////
    // stage 2, haze removal and threshold

    // extra top bit flags a negative difference
    assign diff         = {1'b0, rd_laser} - {1'b0, rd_haze};
    assign diff_clamped = diff[`PT_SAMPLE_W] ? '0 : diff[`PT_SAMPLE_W-1:0];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hit_vld <= 1'b0;
            hit     <= 1'b0;
        end else begin
            hit_vld <= rd_vld;
            hit     <= rd_vld & (diff_clamped > thresh_i);
        end
    end

    assign hit_vld_o = hit_vld;
    assign hit_o     = hit;

endmodule

/* rtl/pingpong_wr_steer.sv */
`timescale 1ns/1ps

module pingpong_wr_steer (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   laser_start_i,
    input  logic                   encode_zero_i,
    input  logic                   laser_pre_vld_i,
    input  pre_track_pkg::sample_t laser_data_i,
    input  pre_track_pkg::sample_t haze_data_i,
    output logic                   wr_bank_b_o,
    output logic                   mema_start_o,
    output logic                   memb_start_o,
    output logic                   mema_vld_o,
    output logic                   memb_vld_o,
    output pre_track_pkg::pair_t   mema_data_o,
    output pre_track_pkg::pair_t   memb_data_o,
    output logic                   second_track_en_o
);
    import pre_track_pkg::*;

    logic  wr_bank_b;
    logic  mema_vld;
    logic  memb_vld;
    logic  second_track_en;
    pair_t wr_pair;

    //////////////////////////////////////////////////
    // bank select

    // 0 writes bank A, 1 writes bank B; every scan starts on A
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_bank_b <= 1'b0;
        end else if (!laser_start_i) begin
            wr_bank_b <= 1'b0;
        end else if (encode_zero_i) begin
            wr_bank_b <= ~wr_bank_b;
        end
    end

    //////////////////////////////////////////////////
    // write strobes and data

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mema_vld <= 1'b0;
            memb_vld <= 1'b0;
        end else begin
            mema_vld <= laser_start_i & laser_pre_vld_i & ~wr_bank_b;
            memb_vld <= laser_start_i & laser_pre_vld_i & wr_bank_b;
        end
    end

    // same word goes to both banks, the strobe picks the target
    always_ff @(posedge clk_i) begin
        wr_pair <= {haze_data_i, laser_data_i};
    end

    // second track armed by the first encoder zero of the scan
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            second_track_en <= 1'b0;
        end else if (!laser_start_i) begin
            second_track_en <= 1'b0;
        end else if (encode_zero_i) begin
            second_track_en <= 1'b1;
        end
    end

    assign wr_bank_b_o       = wr_bank_b;
    assign mema_start_o      = laser_start_i & ~wr_bank_b;
    assign memb_start_o      = laser_start_i & wr_bank_b;
    assign mema_vld_o        = mema_vld;
    assign memb_vld_o        = memb_vld;
    assign mema_data_o       = wr_pair;
    assign memb_data_o       = wr_pair;
    assign second_track_en_o = second_track_en;

endmodule

/* rtl/pre_track_cfg_regs.sv */
`timescale 1ns/1ps

module pre_track_cfg_regs (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    cfg_wr_i,
    input  pre_track_pkg::sample_t  cfg_thresh_i,
    input  pre_track_pkg::win_len_t cfg_win_i,
    output pre_track_pkg::sample_t  thresh_o,
    output pre_track_pkg::win_len_t win_len_o
);
    import pre_track_pkg::*;

    // shortest usable window
    localparam win_len_t win_min = win_len_t'(1);

    win_len_t win_load;

    // a zero window would never look back, treat it as one entry
    always_comb begin
        if (cfg_win_i == '0) begin
            win_load = win_min;
        end else begin
            win_load = cfg_win_i;
        end
    end

    //////////////////////////////////////////////////
    // detection settings

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            thresh_o  <= '0;
            win_len_o <= win_min;
        end else if (cfg_wr_i) begin
            thresh_o  <= cfg_thresh_i;
            win_len_o <= win_load;
        end
    end

endmodule

/* rtl/pre_track_pkg.sv */
`include "pre_track_consts.svh"

package pre_track_pkg;

    // single laser or haze sample
    typedef logic [`PT_SAMPLE_W-1:0] sample_t;

    // bank write word, haze on top and laser below
    typedef logic [2*`PT_SAMPLE_W-1:0] pair_t;

    // readback word, only the low 32 bits are used
    typedef logic [`PT_RD_W-1:0] rd_word_t;

    // history memory address
    typedef logic [`PT_HIST_AW-1:0] hist_addr_t;

    // window length, at most one full history depth
    typedef logic [`PT_HIST_AW-1:0] win_len_t;

    // sum of hits inside the window
    typedef logic [`PT_SUM_W-1:0] hit_sum_t;

endpackage

/* rtl/pre_track_consts.svh */
`ifndef PRE_TRACK_CONSTS_SVH
`define PRE_TRACK_CONSTS_SVH

// laser and haze sample width
`define PT_SAMPLE_W 16

// readback word from the external memory banks
`define PT_RD_W 64

// hit history storage, one bit per readback word
`define PT_HIST_DEPTH 1024
`define PT_HIST_AW 10

// running sum must hold a full window of hits
`define PT_SUM_W 11

`endif
